// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tbFetchStage2
	./obj_dir/VtbFetchStage2 | tee /dev/stderr | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== hw/ctrlPkg.sv ====
package ctrlPkg;
  import fetchPkg::*;

  // the major opcode sits in the top bits of an instruction.
  localparam int opcodeLsb = 26;

  typedef enum logic [5:0] {
    opJump   = 6'h02,
    opCall   = 6'h03,
    opBeq    = 6'h04,
    opBne    = 6'h05,
    opReturn = 6'h08
  } opcode_e;

  typedef enum logic [1:0] {
    ctrlReturn = 2'b00,
    ctrlCall   = 2'b01,
    ctrlJump   = 2'b10,
    ctrlCond   = 2'b11
  } ctrlType_e;

  typedef struct packed {
    logic [pcWidth-1:0] pc;
    ctrlType_e          ctrlType;
    logic               predDir;
    logic [pcWidth-1:0] target;
    logic               taken;
    logic               verified;
  } ctiqEntry_t;

  typedef struct packed {
    logic [pcWidth-1:0] pc;
    logic [pcWidth-1:0] target;
    ctrlType_e          ctrlType;
    logic               dir;
    logic               en;
  } ctrlUpdate_t;

  typedef struct packed {
    logic [ctiqTagWidth-1:0] tag;
    logic [pcWidth-1:0]      target;
    logic                    taken;
    logic                    verified;
  } ctrlResolve_t;

endpackage

// ==== hw/ctrlQueue.sv ====
`timescale 1ns/1ps

module ctrlQueue
  import fetchPkg::*;
  import ctrlPkg::*;
#(
  parameter int ctiqDepth = 16
) (
  input  logic                                    clk,
  input  logic                                    arstN_i,
  input  logic                                    allocEn_i,
  input  logic [fetchWidth-1:0]                   allocVec_i,
  input  logic [fetchWidth-1:0][pcWidth-1:0]      slotPc_i,
  input  ctrlType_e [fetchWidth-1:0]              slotType_i,
  input  logic [fetchWidth-1:0]                   slotPredDir_i,
  input  ctrlResolve_t                            resolve_i,
  input  logic                                    exMispredict_i,
  input  logic                                    recover_i,
  input  logic                                    commit_i,
  output logic [fetchWidth-1:0][ctiqTagWidth-1:0] slotTag_o,
  output logic                                    full_o,
  output ctrlUpdate_t                             update_o
);

  localparam int ptrWidth = $clog2(ctiqDepth);
  localparam int cntWidth = ptrWidth + 1;
  localparam int allocWidth = $clog2(fetchWidth + 1);

  ctiqEntry_t entries [ctiqDepth];

  logic [ptrWidth-1:0]   head;
  logic [ptrWidth-1:0]   tail;
  logic [cntWidth-1:0]   count;
  logic [ptrWidth-1:0]   slotPtr [fetchWidth];
  logic [ptrWidth-1:0]   nextTail;
  logic [allocWidth-1:0] nAlloc;
  logic [ptrWidth-1:0]   resolvePtr;
  logic [ptrWidth-1:0]   truncSpan;
  logic                  pop;
  logic                  updateEn;
  ctiqEntry_t            updateEntry;

  // slots take consecutive entries from the tail, skipping slots not allocated.
  always_comb begin
    logic [ptrWidth-1:0] ptr;
    ptr    = tail;
    nAlloc = '0;
    for (int s = 0; s < fetchWidth; s++) begin
      slotPtr[s]   = ptr;
      slotTag_o[s] = ctiqTagWidth'(ptr);
      if (allocVec_i[s]) begin
        ptr    = ptr + 1'b1;
        nAlloc = nAlloc + 1'b1;
      end
    end
    nextTail = ptr;
  end

  assign full_o     = count > cntWidth'(ctiqDepth - fetchWidth);
  assign pop        = commit_i & (count != '0);
  assign resolvePtr = resolve_i.tag[ptrWidth-1:0];
  assign truncSpan  = resolvePtr - head;

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (recover_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (exMispredict_i) begin
        // everything younger than the mispredicted entry is dropped.
        tail  <= resolvePtr + 1'b1;
        count <= cntWidth'(truncSpan) + cntWidth'(1) - cntWidth'(pop);
      end else if (allocEn_i) begin
        tail  <= nextTail;
        count <= count + cntWidth'(nAlloc) - cntWidth'(pop);
      end else begin
        count <= count - cntWidth'(pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (allocEn_i) begin
      for (int s = 0; s < fetchWidth; s++) begin
        if (allocVec_i[s]) begin
          entries[slotPtr[s]] <= '{pc: slotPc_i[s], ctrlType: slotType_i[s],
                                   predDir: slotPredDir_i[s], target: '0,
                                   taken: 1'b0, verified: 1'b0};
        end
      end
    end
    if (resolve_i.verified) begin
      entries[resolvePtr].target   <= resolve_i.target;
      entries[resolvePtr].taken    <= resolve_i.taken;
      entries[resolvePtr].verified <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      updateEn <= 1'b0;
    end else begin
      updateEn <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      updateEntry <= entries[head];
    end
  end

  assign update_o = '{pc: updateEntry.pc, target: updateEntry.target,
                      ctrlType: updateEntry.ctrlType, dir: updateEntry.taken,
                      en: updateEn};

  initial begin
    assert (ctiqDepth >= 4 && ctiqDepth <= 16 && (ctiqDepth & (ctiqDepth - 1)) == 0)
      else $fatal(1, "ctiqDepth %0d is not a power of two from 4 to 16", ctiqDepth);
  end

  aNoCommitEmpty: assert property (@(posedge clk) disable iff (!arstN_i)
    commit_i |-> count != '0);

  // execute must have verified the oldest entry before commit retires it.
  aCommitVerified: assert property (@(posedge clk) disable iff (!arstN_i)
    pop |-> entries[head].verified);

  aNoAllocFull: assert property (@(posedge clk) disable iff (!arstN_i)
    allocEn_i |-> !full_o);

endmodule

// ==== hw/fetchPkg.sv ====
package fetchPkg;

  localparam int pcWidth = 32;
  localparam int instWidth = 32;
  localparam int fetchWidth = 4;

  // slots in a bundle are this many bytes apart.
  localparam int instStride = 8;

  // queue tags are this wide, so the queue holds at most 16 entries.
  localparam int ctiqTagWidth = 4;

  // slot 0 sits in the low bits of the bundle.
  typedef logic [fetchWidth-1:0][instWidth-1:0] fetchBundle_t;

  typedef struct packed {
    logic               btbHit;
    logic [pcWidth-1:0] btbTarget;
    logic               predDir;
  } slotPred_t;

  typedef struct packed {
    logic [instWidth-1:0]    inst;
    logic [pcWidth-1:0]      pc;
    logic [pcWidth-1:0]      target;
    logic [ctiqTagWidth-1:0] tag;
    logic                    predDir;
  } instPacket_t;

endpackage

// ==== hw/fetchStage2.sv ====
`timescale 1ns/1ps

module fetchStage2
  import fetchPkg::*;
  import ctrlPkg::*;
#(
  parameter int ctiqDepth = 16
) (
  input  logic                          clk,
  input  logic                          arstN_i,
  input  fetchBundle_t                  bundle_i,
  input  logic [pcWidth-1:0]            fetchPc_i,
  input  slotPred_t [fetchWidth-1:0]    slotPred_i,
  input  logic [pcWidth-1:0]            rasTarget_i,
  input  logic                          fs1Ready_i,
  input  logic                          stall_i,
  input  logic                          recover_i,
  input  ctrlResolve_t                  exResolve_i,
  input  logic                          exMispredict_i,
  input  logic                          commit_i,
  output instPacket_t [fetchWidth-1:0]  packet_o,
  output logic [fetchWidth-1:0]         instValid_o,
  output logic                          recoverId_o,
  output logic [pcWidth-1:0]            idTarget_o,
  output logic                          returnId_o,
  output logic                          callId_o,
  output logic [pcWidth-1:0]            callPc_o,
  output ctrlUpdate_t                   update_o,
  output logic                          fs2Ready_o,
  output logic                          ctiqFull_o
);

  logic [fetchWidth-1:0][pcWidth-1:0]      slotPc;
  logic [fetchWidth-1:0][pcWidth-1:0]      decTarget;
  logic [fetchWidth-1:0][pcWidth-1:0]      finalTarget;
  logic [fetchWidth-1:0][ctiqTagWidth-1:0] slotTag;
  ctrlType_e [fetchWidth-1:0]              slotType;
  logic [fetchWidth-1:0]                   isCtrl;
  logic [fetchWidth-1:0]                   slotDir;
  logic [fetchWidth-1:0]                   redirect;
  logic [fetchWidth-1:0]                   condNotTaken;
  logic [fetchWidth-1:0]                   allocVec;
  logic                                    recoverFlag;
  logic                                    allocEn;

  for (genvar s = 0; s < fetchWidth; s++) begin : gSlot
    assign slotPc[s]  = fetchPc_i + pcWidth'(s * instStride);
    assign slotDir[s] = slotPred_i[s].predDir;

    preDecode i_preDecode (
      .pc_i       (slotPc[s]),
      .inst_i     (bundle_i[s]),
      .pred_i     (slotPred_i[s]),
      .isCtrl_o   (isCtrl[s]),
      .ctrlType_o (slotType[s]),
      .target_o   (decTarget[s])
    );

    // anything but a not-taken conditional leaves the sequential path.
    assign redirect[s]     = isCtrl[s] & ((slotType[s] != ctrlCond) | slotDir[s]);
    assign condNotTaken[s] = isCtrl[s] & (slotType[s] == ctrlCond) & ~slotDir[s];

    assign packet_o[s] = '{inst: bundle_i[s], pc: slotPc[s], target: finalTarget[s],
                           tag: slotTag[s], predDir: slotDir[s]};
  end

  always_comb begin
    logic found;
    found       = 1'b0;
    instValid_o = '1;
    allocVec    = condNotTaken;
    finalTarget = decTarget;
    recoverFlag = 1'b0;
    returnId_o  = 1'b0;
    callId_o    = 1'b0;
    idTarget_o  = fetchPc_i + pcWidth'(fetchWidth * instStride);
    callPc_o    = '0;
    for (int s = 0; s < fetchWidth; s++) begin
      if (found) begin
        instValid_o[s] = 1'b0;
        allocVec[s]    = 1'b0;
      end else if (redirect[s]) begin
        found       = 1'b1;
        allocVec[s] = 1'b1;
        idTarget_o  = decTarget[s];
        callPc_o    = slotPc[s];
        // the BTB did not see this transfer, so decode steers fetch instead.
        if (!slotPred_i[s].btbHit) begin
          recoverFlag = 1'b1;
          if (slotType[s] == ctrlReturn) begin
            returnId_o     = 1'b1;
            finalTarget[s] = rasTarget_i;
            idTarget_o     = rasTarget_i;
          end
          if (slotType[s] == ctrlCall) begin
            callId_o = 1'b1;
          end
        end
      end
    end
  end

  assign allocEn     = fs1Ready_i & ~stall_i & ~ctiqFull_o & ~recover_i & ~exMispredict_i;
  assign recoverId_o = recoverFlag & ~stall_i & ~ctiqFull_o;
  assign fs2Ready_o  = fs1Ready_i & ~ctiqFull_o;

  ctrlQueue #(
    .ctiqDepth (ctiqDepth)
  ) i_ctrlQueue (
    .clk            (clk),
    .arstN_i        (arstN_i),
    .allocEn_i      (allocEn),
    .allocVec_i     (allocVec),
    .slotPc_i       (slotPc),
    .slotType_i     (slotType),
    .slotPredDir_i  (slotDir),
    .resolve_i      (exResolve_i),
    .exMispredict_i (exMispredict_i),
    .recover_i      (recover_i),
    .commit_i       (commit_i),
    .slotTag_o      (slotTag),
    .full_o         (ctiqFull_o),
    .update_o       (update_o)
  );

endmodule

// ==== hw/preDecode.sv ====
`timescale 1ns/1ps

module preDecode
  import fetchPkg::*;
  import ctrlPkg::*;
(
  input  logic [pcWidth-1:0]   pc_i,
  input  logic [instWidth-1:0] inst_i,
  input  slotPred_t            pred_i,
  output logic                 isCtrl_o,
  output ctrlType_e            ctrlType_o,
  output logic [pcWidth-1:0]   target_o
);

  opcode_e            opcode;
  logic [pcWidth-1:0] seqPc;
  logic [pcWidth-1:0] offset;
  logic [pcWidth-1:0] directTarget;

  assign opcode = opcode_e'(inst_i[opcodeLsb +: $bits(opcode_e)]);
  assign seqPc  = pc_i + pcWidth'(instStride);

  // the immediate counts instructions, so it is scaled by the slot stride.
  assign offset = {{(pcWidth-16){inst_i[15]}}, inst_i[15:0]} << $clog2(instStride);
  assign directTarget = seqPc + offset;

  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = ctrlJump;
    target_o   = seqPc;
    case (opcode)
      opJump: begin
        ctrlType_o = ctrlJump;
        target_o   = directTarget;
      end
      opCall: begin
        ctrlType_o = ctrlCall;
        target_o   = directTarget;
      end
      opReturn: begin
        // a return has no direct target, the BTB supplies it.
        ctrlType_o = ctrlReturn;
        target_o   = pred_i.btbTarget;
      end
      opBeq, opBne: begin
        ctrlType_o = ctrlCond;
        target_o   = pred_i.predDir ? directTarget : seqPc;
      end
      default: begin
        isCtrl_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== sim/fetchChecker.sv ====
`timescale 1ns/1ps

module fetchChecker
  import fetchPkg::*;
  import ctrlPkg::*;
(
  input logic                         clk,
  input logic                         arstN_i,
  input fetchBundle_t                 bundle_i,
  input logic [pcWidth-1:0]           fetchPc_i,
  input slotPred_t [fetchWidth-1:0]   slotPred_i,
  input logic [pcWidth-1:0]           rasTarget_i,
  input logic                         fs1Ready_i,
  input logic                         stall_i,
  input logic                         recover_i,
  input ctrlResolve_t                 exResolve_i,
  input logic                         exMispredict_i,
  input logic                         commit_i,
  input instPacket_t [fetchWidth-1:0] packet_o,
  input logic [fetchWidth-1:0]        instValid_o,
  input logic                         recoverId_o,
  input logic [pcWidth-1:0]           idTarget_o,
  input logic                         returnId_o,
  input logic                         callId_o,
  input logic [pcWidth-1:0]           callPc_o,
  input ctrlUpdate_t                  update_o,
  input logic                         fs2Ready_o,
  input logic                         ctiqFull_o
);

  logic [3:0]         mHead;
  logic [3:0]         mTail;
  logic [4:0]         mCount;
  logic [pcWidth-1:0] mPc [16];
  ctrlType_e          mType [16];
  logic [pcWidth-1:0] mTarget [16];
  logic               mTaken [16];
  logic               mVerified [16];
  ctrlUpdate_t        mUpd;
  ctrlType_e          mSlotType [fetchWidth];
  logic [3:0]         mAlloc;
  logic [3:0]         mNumAlloc;
  logic               mAllocEn;
  int                 errCount = 0;
  int                 checkCount = 0;

  task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // outputs are settled at the falling edge, half a cycle after the inputs change.
  always @(negedge clk) begin
    logic [31:0] pc;
    logic [31:0] tgt;
    logic [31:0] offset;
    logic [31:0] expId;
    logic [31:0] expCallPc;
    logic        ctrl;
    logic        notTaken;
    logic        found;
    logic        flag;
    logic        retF;
    logic        callF;
    logic        full;
    logic [3:0]  ptr;
    logic [3:0]  valid;
    logic [3:0]  alloc;
    ctrlType_e   typ;
    if (arstN_i) begin
      found = 1'b0;
      flag = 1'b0;
      retF = 1'b0;
      callF = 1'b0;
      valid = '1;
      alloc = '0;
      ptr = mTail;
      mNumAlloc = '0;
      expId = '0;
      expCallPc = '0;
      full = mCount > 5'd12;
      for (int s = 0; s < fetchWidth; s++) begin
        pc = fetchPc_i + 32'(8 * s);
        offset = {{16{bundle_i[s][15]}}, bundle_i[s][15:0]} << 3;
        ctrl = 1'b1;
        typ = ctrlJump;
        case (bundle_i[s][31:26])
          opJump: typ = ctrlJump;
          opCall: typ = ctrlCall;
          opReturn: typ = ctrlReturn;
          opBeq, opBne: typ = ctrlCond;
          default: ctrl = 1'b0;
        endcase
        notTaken = ctrl && typ == ctrlCond && !slotPred_i[s].predDir;
        if (!ctrl || notTaken) tgt = pc + 32'd8;
        else if (typ == ctrlReturn) tgt = slotPred_i[s].btbTarget;
        else tgt = pc + 32'd8 + offset;
        if (found) begin
          valid[s] = 1'b0;
        end else if (ctrl && !notTaken) begin
          found = 1'b1;
          alloc[s] = 1'b1;
          if (!slotPred_i[s].btbHit) begin
            flag = 1'b1;
            retF = typ == ctrlReturn;
            callF = typ == ctrlCall;
            expCallPc = pc;
            if (retF) tgt = rasTarget_i;
          end
          expId = tgt;
        end else if (notTaken) begin
          alloc[s] = 1'b1;
        end
        expectEq($sformatf("slot %0d inst", s), packet_o[s].inst, bundle_i[s]);
        expectEq($sformatf("slot %0d pc", s), packet_o[s].pc, pc);
        expectEq($sformatf("slot %0d target", s), packet_o[s].target, tgt);
        expectEq($sformatf("slot %0d predDir", s), 32'(packet_o[s].predDir),
                 32'(slotPred_i[s].predDir));
        expectEq($sformatf("slot %0d tag", s), 32'(packet_o[s].tag), 32'(ptr));
        mSlotType[s] = typ;
        if (alloc[s]) begin
          ptr = ptr + 4'd1;
          mNumAlloc = mNumAlloc + 4'd1;
        end
      end
      expectEq("instValid", 32'(instValid_o), 32'(valid));
      expectEq("recoverId", 32'(recoverId_o), 32'(flag && !stall_i && !full));
      expectEq("returnId", 32'(returnId_o), 32'(retF));
      expectEq("callId", 32'(callId_o), 32'(callF));
      if (found) expectEq("idTarget", idTarget_o, expId);
      if (callF) expectEq("callPc", callPc_o, expCallPc);
      expectEq("ctiqFull", 32'(ctiqFull_o), 32'(full));
      expectEq("fs2Ready", 32'(fs2Ready_o), 32'(fs1Ready_i && !full));
      expectEq("update en", 32'(update_o.en), 32'(mUpd.en));
      if (mUpd.en) begin
        expectEq("update pc", update_o.pc, mUpd.pc);
        expectEq("update target", update_o.target, mUpd.target);
        expectEq("update type", 32'(update_o.ctrlType), 32'(mUpd.ctrlType));
        expectEq("update dir", 32'(update_o.dir), 32'(mUpd.dir));
      end
      mAlloc = alloc;
      mAllocEn = fs1Ready_i && !stall_i && !full && !recover_i && !exMispredict_i;
    end
  end

  always @(posedge clk or negedge arstN_i) begin
    logic       pop;
    logic [3:0] ptr;
    logic [3:0] span;
    if (!arstN_i) begin
      mHead <= '0;
      mTail <= '0;
      mCount <= '0;
      mUpd <= '0;
    end else begin
      pop = commit_i && mCount != '0;
      span = exResolve_i.tag - mHead;
      if (pop) begin
        mUpd <= '{pc: mPc[mHead], target: mTarget[mHead], ctrlType: mType[mHead],
                  dir: mTaken[mHead], en: 1'b1};
      end else begin
        mUpd.en <= 1'b0;
      end
      if (recover_i) begin
        mHead <= '0;
        mTail <= '0;
        mCount <= '0;
      end else begin
        if (pop) mHead <= mHead + 4'd1;
        if (exMispredict_i) begin
          mTail <= exResolve_i.tag + 4'd1;
          mCount <= 5'(span) + 5'd1 - 5'(pop);
        end else if (mAllocEn) begin
          mTail <= mTail + mNumAlloc;
          mCount <= mCount + 5'(mNumAlloc) - 5'(pop);
        end else begin
          mCount <= mCount - 5'(pop);
        end
      end
      ptr = mTail;
      for (int s = 0; s < fetchWidth; s++) begin
        if (mAllocEn && mAlloc[s]) begin
          mPc[ptr] <= fetchPc_i + 32'(8 * s);
          mType[ptr] <= mSlotType[s];
          mVerified[ptr] <= 1'b0;
          ptr = ptr + 4'd1;
        end
      end
      if (exResolve_i.verified) begin
        mTarget[exResolve_i.tag] <= exResolve_i.target;
        mTaken[exResolve_i.tag] <= exResolve_i.taken;
        mVerified[exResolve_i.tag] <= 1'b1;
      end
    end
  end

endmodule

// ==== sim/tbFetchStage2.sv ====
`timescale 1ns/1ps

module tbFetchStage2
  import fetchPkg::*;
  import ctrlPkg::*;
;

  localparam int randomCycles = 2000;
  localparam int cycleLimit = 2600;

  logic                                clk;
  logic                                arstN_i;
  fetchBundle_t                        bundle_i;
  logic [pcWidth-1:0]                  fetchPc_i;
  slotPred_t [fetchWidth-1:0]          slotPred_i;
  logic [pcWidth-1:0]                  rasTarget_i;
  logic                                fs1Ready_i;
  logic                                stall_i;
  logic                                recover_i;
  ctrlResolve_t                        exResolve_i;
  logic                                exMispredict_i;
  logic                                commit_i;
  instPacket_t [fetchWidth-1:0]        packet_o;
  logic [fetchWidth-1:0]               instValid_o;
  logic                                recoverId_o;
  logic [pcWidth-1:0]                  idTarget_o;
  logic                                returnId_o;
  logic                                callId_o;
  logic [pcWidth-1:0]                  callPc_o;
  ctrlUpdate_t                         update_o;
  logic                                fs2Ready_o;
  logic                                ctiqFull_o;

  int   seed = 32'h97bf_2554;
  int   cycles = 0;
  // set when the last drive could move the queue head or tail.
  logic prevHold = 1'b0;

  fetchStage2 #(.ctiqDepth(16)) i_dut (.*);

  fetchChecker i_check (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles.", cycleLimit);
      $display("Verification failed");
      $finish;
    end
  end

  // about 40 % control opcodes, the rest anything that decodes as plain.
  function automatic logic [instWidth-1:0] randomInst();
    logic [31:0] r;
    logic [31:0] inst;
    r    = $random(seed);
    inst = $random(seed);
    if (r[7:0] < 8'd102) begin
      case (r[10:8])
        3'd0: inst[31:26] = opJump;
        3'd1: inst[31:26] = opCall;
        3'd2: inst[31:26] = opReturn;
        3'd3, 3'd4: inst[31:26] = opBeq;
        default: inst[31:26] = opBne;
      endcase
    end else begin
      case (inst[31:26])
        opJump, opCall, opReturn, opBeq, opBne: inst[31:26] = 6'h3f;
        default: ;
      endcase
    end
    return inst;
  endfunction

  task automatic driveQuiet();
    exResolve_i    <= '0;
    exMispredict_i <= 1'b0;
    recover_i      <= 1'b0;
    commit_i       <= 1'b0;
  endtask

  task automatic driveRandom();
    logic [31:0] r;
    logic [3:0]  head;
    int          live;
    logic        misp;
    logic        rec;
    logic        com;
    fetchBundle_t b;
    slotPred_t [fetchWidth-1:0] p;
    r    = $random(seed);
    head = i_check.mHead;
    live = int'(i_check.mCount);
    for (int s = 0; s < fetchWidth; s++) begin
      b[s]           = randomInst();
      p[s].btbHit    = r[24 + s];
      p[s].predDir   = r[28 + s];
      p[s].btbTarget = $random(seed);
    end
    misp = !prevHold && live != 0 && r[11:6] == 6'd0;
    rec  = !misp && r[18:12] == 7'd0;
    com  = !prevHold && !misp && !rec && live != 0 &&
           i_check.mVerified[head] === 1'b1 && r[21];
    bundle_i       <= b;
    slotPred_i     <= p;
    fetchPc_i      <= $random(seed) & 32'hffff_fff8;
    rasTarget_i    <= $random(seed);
    fs1Ready_i     <= r[0] | r[1];
    stall_i        <= r[2] & r[3];
    exMispredict_i <= misp;
    recover_i      <= rec;
    commit_i       <= com;
    exResolve_i    <= '0;
    if (live != 0 && (r[20] || misp)) begin
      exResolve_i <= '{tag: head + 4'({$random(seed)} % live), target: $random(seed),
                       taken: r[22], verified: 1'b1};
    end
    prevHold = com | misp | rec;
  endtask

  initial begin
    clk = 1'b0;
    arstN_i = 1'b0;
    bundle_i = '0;
    fetchPc_i = '0;
    slotPred_i = '0;
    rasTarget_i = '0;
    fs1Ready_i = 1'b0;
    stall_i = 1'b0;
    recover_i = 1'b0;
    exResolve_i = '0;
    exMispredict_i = 1'b0;
    commit_i = 1'b0;
    repeat (16) @(posedge clk);
    arstN_i <= 1'b1;
    repeat (randomCycles) begin
      @(posedge clk);
      driveRandom();
    end
    // fill the queue with not-taken conditionals until it reports full.
    do begin
      @(posedge clk);
      driveQuiet();
      for (int s = 0; s < fetchWidth; s++) begin
        bundle_i[s] <= {opBeq, 10'd0, 16'($random(seed))};
        slotPred_i[s] <= '{btbHit: 1'b1, btbTarget: 32'h0, predDir: 1'b0};
      end
      fs1Ready_i <= 1'b1;
      stall_i <= 1'b0;
    end while (!ctiqFull_o);
    @(posedge clk);
    driveQuiet();
    fs1Ready_i <= 1'b0;
    for (int i = 0; i < int'(i_check.mCount); i++) begin
      @(posedge clk);
      exResolve_i <= '{tag: i_check.mHead + 4'(i), target: $random(seed),
                       taken: 1'($random(seed)), verified: 1'b1};
    end
    // retire every entry, leaving a gap so the model head has moved before the next commit.
    prevHold = 1'b0;
    while (i_check.mCount != '0) begin
      @(posedge clk);
      driveQuiet();
      if (!prevHold && i_check.mCount != '0 && i_check.mVerified[i_check.mHead] === 1'b1) begin
        commit_i <= 1'b1;
        prevHold = 1'b1;
      end else begin
        prevHold = 1'b0;
      end
    end
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", i_check.checkCount, i_check.errCount);
    if (i_check.errCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
hw/fetchPkg.sv
hw/ctrlPkg.sv
hw/preDecode.sv
hw/ctrlQueue.sv
hw/fetchStage2.sv
sim/fetchChecker.sv
sim/tbFetchStage2.sv
